//--- include/core_defines.svh
/*
 * Widths and data RAM size for the execute/memory pipeline.
 * DMEM_AW must equal log2 of DMEM_WORDS. Addresses above the RAM wrap.
 */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// ************************************************************************
// Datapath
// ************************************************************************

// Data and address width of the core
`define XLEN 32

// ************************************************************************
// Data RAM
// ************************************************************************

// Depth in 32-bit words and the matching word address width
`define DMEM_WORDS 256
`define DMEM_AW 8

`endif

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass message in the log

rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
	--top-module tb_core_exe_mem --Mdir obj_dir > build.log 2>&1 \
	&& ./obj_dir/Vtb_core_exe_mem > sim.log 2>&1 \
	|| echo "Verilator build or simulation returned an error, see build.log and sim.log"

grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/tb_core_exe_mem.sv
/*
 * Table-driven testbench with a reference register file and data memory.
 * Loads only read words that a full word store has written before.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_core_exe_mem;

	logic                    clk;
	logic                    rst_n;
	logic                    exe_enb;
	logic                    exe_kill;
	core_data_pkg::exe_in_t  exe_in;
	logic                    brnch_taken;
	core_data_pkg::mem_wb_t  wb;

	// Stimulus table with one instruction per cycle
	core_data_pkg::exe_in_t  step_q[$];
	logic                    enb_q[$];
	logic                    kill_q[$];
	logic                    kill_pending;

	// Reference model state
	logic [`XLEN-1:0]        rf [32];
	logic [`XLEN-1:0]        ref_mem [`DMEM_WORDS];
	core_data_pkg::mem_wb_t  pend_q[$];
	core_data_pkg::mem_wb_t  exp_em;
	core_data_pkg::mem_wb_t  exp_wb;
	core_data_pkg::mem_wb_t  exp_new;
	core_data_pkg::mem_wb_t  retired;
	core_data_pkg::exe_in_t  ins;
	logic                    exp_taken;
	logic [`XLEN-1:0]        op1;
	logic [`XLEN-1:0]        op2;
	logic [`XLEN-1:0]        alu_a;
	logic [`XLEN-1:0]        alu_b;
	logic [`XLEN-1:0]        cur_addr;
	logic [31:0]             lfsr_state;
	int                      n_checks;
	int                      wb_errors;
	int                      br_errors;

	core_exe_mem i_core_exe_mem (
		.clk         (clk),
		.rst_n       (rst_n),
		.exe_enb     (exe_enb),
		.exe_kill    (exe_kill),
		.exe_in      (exe_in),
		.brnch_taken (brnch_taken),
		.wb          (wb)
	);

	always #2 clk = ~clk;

	// ************************************************************************
	// Reference model
	// ************************************************************************

	// Galois LFSR stepped once for every bit handed out
	function automatic logic [31:0] rand_bits(input int nbits);
		logic [31:0] v;
		logic        out_bit;
		v = '0;
		for (int k = 0; k < nbits; k++) begin
			out_bit = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (out_bit)
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			v = {v[30:0], out_bit};
		end
		return v;
	endfunction

	// Newest in-flight write of a register wins over the register file
	function automatic logic [`XLEN-1:0] arch_reg(input logic [4:0] r);
		logic [`XLEN-1:0] v;
		v = rf[r];
		foreach (pend_q[k]) begin
			if (pend_q[k].we && (pend_q[k].rd == r) && (r != 5'd0))
				v = pend_q[k].data;
		end
		return v;
	endfunction

	function automatic logic [`XLEN-1:0] alu_model(input core_ctrl_pkg::alu_op_t op,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic [63:0]      sext;
		logic [`XLEN-1:0] r;
		sext = {{32{a[31]}}, a} >> b[4:0];
		case (op)
			core_ctrl_pkg::ALU_ADD:    r = a + b;
			core_ctrl_pkg::ALU_SUB:    r = a + ~b + 32'd1;
			core_ctrl_pkg::ALU_AND:    r = a & b;
			core_ctrl_pkg::ALU_OR:     r = a | b;
			core_ctrl_pkg::ALU_XOR:    r = a ^ b;
			core_ctrl_pkg::ALU_SLL:    r = a << b[4:0];
			core_ctrl_pkg::ALU_SRL:    r = a >> b[4:0];
			core_ctrl_pkg::ALU_SRA:    r = sext[31:0];
			core_ctrl_pkg::ALU_SLT:    r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
			core_ctrl_pkg::ALU_SLTU:   r = {31'd0, a < b};
			core_ctrl_pkg::ALU_PASS_B: r = b;
			default:                   r = '0;
		endcase
		return r;
	endfunction

	function automatic logic branch_model(input core_ctrl_pkg::brnch_cnd_t cnd,
		input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic lt_s;
		lt_s = (a[31] != b[31]) ? a[31] : (a < b);
		case (cnd)
			core_ctrl_pkg::BR_EQ:  return a == b;
			core_ctrl_pkg::BR_NE:  return a != b;
			core_ctrl_pkg::BR_LT:  return lt_s;
			core_ctrl_pkg::BR_GE:  return !lt_s;
			core_ctrl_pkg::BR_LTU: return a < b;
			core_ctrl_pkg::BR_GEU: return a >= b;
			default:               return 1'b0;
		endcase
	endfunction

	function automatic logic [`XLEN-1:0] load_model(input core_ctrl_pkg::wb_ext_t ext,
		input logic [`XLEN-1:0] addr);
		logic [`XLEN-1:0] word;
		logic [7:0]       bt;
		logic [15:0]      hf;
		word = ref_mem[addr[`DMEM_AW+1:2]];
		bt   = word[8*addr[1:0] +: 8];
		hf   = addr[1] ? word[31:16] : word[15:0];
		case (ext)
			core_ctrl_pkg::WB_EXT_SB: return {{24{bt[7]}}, bt};
			core_ctrl_pkg::WB_EXT_UB: return {24'd0, bt};
			core_ctrl_pkg::WB_EXT_SH: return {{16{hf[15]}}, hf};
			core_ctrl_pkg::WB_EXT_UH: return {16'd0, hf};
			default:                  return word;
		endcase
	endfunction

	task automatic store_model(input core_ctrl_pkg::mem_size_t size,
		input logic [`XLEN-1:0] addr, input logic [`XLEN-1:0] data);
		logic [`DMEM_AW-1:0] idx;
		idx = addr[`DMEM_AW+1:2];
		case (size)
			core_ctrl_pkg::MEM_SIZE_B: ref_mem[idx][8*addr[1:0] +: 8] = data[7:0];
			core_ctrl_pkg::MEM_SIZE_H: begin
				if (addr[1])
					ref_mem[idx][31:16] = data[15:0];
				else
					ref_mem[idx][15:0] = data[15:0];
			end
			default: ref_mem[idx] = data;
		endcase
	endtask

	// ************************************************************************
	// Table builders
	// ************************************************************************

	function automatic core_data_pkg::exe_in_t nop_instr();
		core_data_pkg::exe_in_t n;
		n = '0;
		n.alu_op    = core_ctrl_pkg::ALU_ADD;
		n.brnch_cnd = core_ctrl_pkg::BR_NONE;
		n.mem_acc   = core_ctrl_pkg::MEM_NOT_REQ;
		n.wb_ext    = core_ctrl_pkg::WB_EXT_BP;
		return n;
	endfunction

	function automatic core_ctrl_pkg::mem_acc_t mem_access(input logic write,
		input core_ctrl_pkg::mem_size_t size);
		core_ctrl_pkg::mem_acc_t acc;
		acc.spare = 3'b000;
		acc.req   = core_ctrl_pkg::MEM_REQ;
		acc.write = write;
		acc.size  = size;
		return acc;
	endfunction

	task automatic push_step(input core_data_pkg::exe_in_t s, input logic enb);
		s.pc   = 32'h0000_1000 + 32'(4 * step_q.size());
		s.pc_4 = s.pc + 32'd4;
		step_q.push_back(s);
		enb_q.push_back(enb);
		kill_q.push_back(kill_pending);
		kill_pending = 1'b0;
	endtask

	task automatic alu_rr(input core_ctrl_pkg::alu_op_t op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [4:0] rs2);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.alu_op = op;
		s.rd  = rd;
		s.rs1 = rs1;
		s.rs2 = rs2;
		s.we  = 1'b1;
		push_step(s, 1'b1);
	endtask

	task automatic alu_ri(input core_ctrl_pkg::alu_op_t op, input logic [4:0] rd,
		input logic [4:0] rs1, input logic [31:0] imm);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.alu_op   = op;
		s.rd       = rd;
		s.rs1      = rs1;
		s.imm      = imm;
		s.b_is_imm = 1'b1;
		s.we       = 1'b1;
		push_step(s, 1'b1);
	endtask

	// The pc is ALU operand A and the immediate is operand B
	task automatic pc_add(input logic [4:0] rd, input logic [31:0] imm);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.rd       = rd;
		s.imm      = imm;
		s.a_is_pc  = 1'b1;
		s.b_is_imm = 1'b1;
		s.we       = 1'b1;
		push_step(s, 1'b1);
	endtask

	task automatic branch_rr(input core_ctrl_pkg::brnch_cnd_t cnd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.brnch_cnd = cnd;
		s.rs1 = rs1;
		s.rs2 = rs2;
		push_step(s, 1'b1);
	endtask

	// Jump and link writes pc_4 to rd while the ALU forms the target
	task automatic jump_link(input logic [4:0] rd, input logic [31:0] imm);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.rd           = rd;
		s.imm          = imm;
		s.a_is_pc      = 1'b1;
		s.b_is_imm     = 1'b1;
		s.addr_base_pc = 1'b1;
		s.link         = 1'b1;
		s.we           = 1'b1;
		push_step(s, 1'b1);
	endtask

	task automatic store_op(input core_ctrl_pkg::mem_size_t size, input logic [4:0] base,
		input logic [4:0] data_reg, input logic [31:0] imm);
		core_data_pkg::exe_in_t s;
		s = nop_instr();
		s.rs1      = base;
		s.rs2      = data_reg;
		s.imm      = imm;
		s.b_is_imm = 1'b1;
		s.mem_acc  = mem_access(1'b1, size);
		push_step(s, 1'b1);
	endtask

	task automatic load_op(input core_ctrl_pkg::wb_ext_t ext, input logic [4:0] rd,
		input logic [4:0] base, input logic [31:0] imm);
		core_data_pkg::exe_in_t s;
		core_ctrl_pkg::mem_size_t size;
		if ((ext == core_ctrl_pkg::WB_EXT_SB) || (ext == core_ctrl_pkg::WB_EXT_UB))
			size = core_ctrl_pkg::MEM_SIZE_B;
		else if ((ext == core_ctrl_pkg::WB_EXT_SH) || (ext == core_ctrl_pkg::WB_EXT_UH))
			size = core_ctrl_pkg::MEM_SIZE_H;
		else
			size = core_ctrl_pkg::MEM_SIZE_W;
		s = nop_instr();
		s.rd       = rd;
		s.rs1      = base;
		s.imm      = imm;
		s.b_is_imm = 1'b1;
		s.we       = 1'b1;
		s.wb_ext   = ext;
		s.mem_acc  = mem_access(1'b0, size);
		push_step(s, 1'b1);
	endtask

	// Word load from a pc-relative address that lands on target
	task automatic load_pc_rel(input logic [4:0] rd, input logic [31:0] target);
		core_data_pkg::exe_in_t s;
		load_op(core_ctrl_pkg::WB_EXT_W, rd, 5'd0, 32'h0);
		s = step_q.pop_back();
		s.addr_base_pc = 1'b1;
		s.imm          = target - s.pc;
		step_q.push_back(s);
	endtask

	task automatic stall(input int n);
		for (int k = 0; k < n; k++)
			push_step(nop_instr(), 1'b0);
	endtask

	task automatic build_table();
		// Every ALU operation on random register values
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd3, 5'd1, 5'd2);
		alu_rr(core_ctrl_pkg::ALU_SUB, 5'd4, 5'd5, 5'd6);
		alu_rr(core_ctrl_pkg::ALU_AND, 5'd7, 5'd8, 5'd9);
		alu_rr(core_ctrl_pkg::ALU_OR, 5'd10, 5'd11, 5'd12);
		alu_rr(core_ctrl_pkg::ALU_XOR, 5'd13, 5'd14, 5'd15);
		alu_rr(core_ctrl_pkg::ALU_SLL, 5'd16, 5'd17, 5'd18);
		alu_rr(core_ctrl_pkg::ALU_SRL, 5'd20, 5'd21, 5'd22);
		alu_rr(core_ctrl_pkg::ALU_SRA, 5'd23, 5'd24, 5'd25);
		alu_rr(core_ctrl_pkg::ALU_SLT, 5'd26, 5'd27, 5'd28);
		alu_rr(core_ctrl_pkg::ALU_SLTU, 5'd29, 5'd30, 5'd31);
		alu_rr(core_ctrl_pkg::ALU_PASS_B, 5'd19, 5'd1, 5'd2);
		alu_ri(core_ctrl_pkg::ALU_SRA, 5'd24, 5'd17, 32'h0000_0007);
		// Back to back and one apart, then memory beats writeback on the same rd
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd3, 5'd1, 5'd2);
		alu_rr(core_ctrl_pkg::ALU_SUB, 5'd4, 5'd3, 5'd1);
		alu_rr(core_ctrl_pkg::ALU_XOR, 5'd5, 5'd3, 5'd4);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd6, 5'd1, 5'd2);
		alu_rr(core_ctrl_pkg::ALU_OR, 5'd6, 5'd4, 5'd5);
		alu_rr(core_ctrl_pkg::ALU_AND, 5'd7, 5'd6, 5'd6);
		alu_ri(core_ctrl_pkg::ALU_ADD, 5'd0, 5'd1, 32'h0);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd8, 5'd0, 5'd2);
		// Branch conditions on register and forwarded operands
		branch_rr(core_ctrl_pkg::BR_EQ, 5'd1, 5'd1);
		branch_rr(core_ctrl_pkg::BR_EQ, 5'd1, 5'd2);
		branch_rr(core_ctrl_pkg::BR_NE, 5'd1, 5'd2);
		branch_rr(core_ctrl_pkg::BR_LT, 5'd1, 5'd2);
		branch_rr(core_ctrl_pkg::BR_LT, 5'd2, 5'd1);
		branch_rr(core_ctrl_pkg::BR_GE, 5'd1, 5'd2);
		branch_rr(core_ctrl_pkg::BR_LTU, 5'd1, 5'd2);
		branch_rr(core_ctrl_pkg::BR_GEU, 5'd1, 5'd2);
		alu_ri(core_ctrl_pkg::ALU_ADD, 5'd9, 5'd0, 32'hFFFF_FFFF);
		branch_rr(core_ctrl_pkg::BR_LT, 5'd9, 5'd0);
		branch_rr(core_ctrl_pkg::BR_LTU, 5'd0, 5'd9);
		branch_rr(core_ctrl_pkg::BR_GEU, 5'd9, 5'd0);
		branch_rr(core_ctrl_pkg::BR_NONE, 5'd1, 5'd1);
		jump_link(5'd19, 32'h0000_0040);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd20, 5'd19, 5'd0);
		pc_add(5'd27, 32'h0000_0100);
		// Stores of each size, then loads with every extension
		alu_ri(core_ctrl_pkg::ALU_ADD, 5'd25, 5'd0, 32'h0000_0080);
		store_op(core_ctrl_pkg::MEM_SIZE_W, 5'd25, 5'd6, 32'h0);
		store_op(core_ctrl_pkg::MEM_SIZE_W, 5'd0, 5'd7, 32'h0000_0084);
		store_op(core_ctrl_pkg::MEM_SIZE_B, 5'd25, 5'd8, 32'h0000_0001);
		store_op(core_ctrl_pkg::MEM_SIZE_H, 5'd25, 5'd9, 32'h0000_0006);
		load_op(core_ctrl_pkg::WB_EXT_SB, 5'd10, 5'd25, 32'h0000_0001);
		load_op(core_ctrl_pkg::WB_EXT_UB, 5'd11, 5'd0, 32'h0000_0083);
		load_op(core_ctrl_pkg::WB_EXT_SH, 5'd12, 5'd0, 32'h0000_0086);
		load_op(core_ctrl_pkg::WB_EXT_UH, 5'd13, 5'd0, 32'h0000_0080);
		load_op(core_ctrl_pkg::WB_EXT_W, 5'd14, 5'd0, 32'h0000_0084);
		push_step(nop_instr(), 1'b1);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd15, 5'd14, 5'd10);
		load_pc_rel(5'd26, 32'h0000_0080);
		// Killed store and killed ALU result
		kill_pending = 1'b1;
		store_op(core_ctrl_pkg::MEM_SIZE_W, 5'd0, 5'd20, 32'h0000_0084);
		load_op(core_ctrl_pkg::WB_EXT_W, 5'd16, 5'd0, 32'h0000_0084);
		kill_pending = 1'b1;
		alu_ri(core_ctrl_pkg::ALU_ADD, 5'd17, 5'd0, 32'h0000_0055);
		push_step(nop_instr(), 1'b1);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd18, 5'd17, 5'd0);
		// Back-pressure with dependences held across the stall
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd21, 5'd1, 5'd2);
		alu_rr(core_ctrl_pkg::ALU_SUB, 5'd22, 5'd21, 5'd1);
		stall(4);
		alu_rr(core_ctrl_pkg::ALU_XOR, 5'd23, 5'd22, 5'd21);
		alu_rr(core_ctrl_pkg::ALU_ADD, 5'd24, 5'd23, 5'd22);
		push_step(nop_instr(), 1'b1);
		push_step(nop_instr(), 1'b1);
	endtask

	// ************************************************************************
	// Checks
	// ************************************************************************

	task automatic check_wb(input core_data_pkg::mem_wb_t got,
		input core_data_pkg::mem_wb_t want, input int step);
		n_checks++;
		if (got !== want) begin
			wb_errors++;
			$display("MISMATCH wb step %0d: got we=%h rd=%h data=%h, want we=%h rd=%h data=%h",
				step, got.we, got.rd, got.data, want.we, want.rd, want.data);
		end
	endtask

	task automatic check_branch(input logic got, input logic want, input int step);
		n_checks++;
		if (got !== want) begin
			br_errors++;
			$display("MISMATCH brnch_taken at step %0d: got %h expected %h", step, got, want);
		end
	endtask

	// Run limit scales with the table, which is built at time zero
	initial begin
		#1;
		#((step_q.size() + 24) * 16);
		$display("Watchdog expired before the stimulus table completed");
		$display("Some tests failed");
		$finish;
	end

	initial begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		exe_enb      = 1'b0;
		exe_kill     = 1'b0;
		exe_in       = '0;
		kill_pending = 1'b0;
		lfsr_state   = 32'd3;
		n_checks     = 0;
		wb_errors    = 0;
		br_errors    = 0;
		exp_em       = '0;
		exp_wb       = '0;
		build_table();
		rf[0] = '0;
		for (int r = 1; r < 32; r++)
			rf[r] = rand_bits(32);

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		for (int i = 0; i < step_q.size(); i++) begin
			@(negedge clk);
			if (i > 0)
				check_wb(wb, exp_wb, i - 1);
			ins = step_q[i];
			op1 = arch_reg(ins.rs1);
			op2 = arch_reg(ins.rs2);
			// The DUT gets register file values, so dependences need the bypass
			ins.src1 = rf[ins.rs1];
			ins.src2 = rf[ins.rs2];
			alu_a    = ins.a_is_pc ? ins.pc : op1;
			alu_b    = ins.b_is_imm ? ins.imm : op2;
			cur_addr = ins.imm + (ins.addr_base_pc ? ins.pc : op1);
			exp_taken  = branch_model(ins.brnch_cnd, alu_a, alu_b);
			exp_new.we = ins.we;
			exp_new.rd = ins.rd;
			if ((ins.mem_acc.req == core_ctrl_pkg::MEM_REQ) && !ins.mem_acc.write)
				exp_new.data = load_model(ins.wb_ext, cur_addr);
			else
				exp_new.data = ins.link ? ins.pc_4 : alu_model(ins.alu_op, alu_a, alu_b);
			exe_in   = ins;
			exe_enb  = enb_q[i];
			exe_kill = kill_q[i];
			#1;
			check_branch(brnch_taken, exp_taken, i);

			@(posedge clk);
			if (enb_q[i]) begin
				exp_wb = exp_em;
				exp_em = kill_q[i] ? '0 : exp_new;
				pend_q.push_back(exp_em);
				if (pend_q.size() > 2) begin
					retired = pend_q.pop_front();
					if (retired.we && (retired.rd != 5'd0))
						rf[retired.rd] = retired.data;
				end
				if (!kill_q[i] && (ins.mem_acc.req == core_ctrl_pkg::MEM_REQ) &&
					ins.mem_acc.write)
					store_model(ins.mem_acc.size, cur_addr, op2);
			end
		end
		@(negedge clk);
		check_wb(wb, exp_wb, step_q.size() - 1);

		$display("Checks: %0d, wb mismatches: %0d, brnch_taken mismatches: %0d",
			n_checks, wb_errors, br_errors);
		if ((wb_errors + br_errors) == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/core_alu.sv
/*
 * Combinational ALU and branch comparator.
 * Branch condition none never reports taken.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_alu (
	input  logic [`XLEN-1:0]          src1,
	input  logic [`XLEN-1:0]          src2,
	input  core_ctrl_pkg::alu_op_t    alu_op,
	input  core_ctrl_pkg::brnch_cnd_t brnch_cnd,
	output logic [`XLEN-1:0]          alu_result,
	output logic                      brnch_taken
);

	logic signed_lt;
	logic unsigned_lt;
	logic equal;

	assign signed_lt   = $signed(src1) < $signed(src2);
	assign unsigned_lt = src1 < src2;
	assign equal       = src1 == src2;

	always_comb begin
		case (alu_op)
			core_ctrl_pkg::ALU_ADD:    alu_result = src1 + src2;
			core_ctrl_pkg::ALU_SUB:    alu_result = src1 - src2;
			core_ctrl_pkg::ALU_AND:    alu_result = src1 & src2;
			core_ctrl_pkg::ALU_OR:     alu_result = src1 | src2;
			core_ctrl_pkg::ALU_XOR:    alu_result = src1 ^ src2;
			core_ctrl_pkg::ALU_SLL:    alu_result = src1 << src2[4:0];
			core_ctrl_pkg::ALU_SRL:    alu_result = src1 >> src2[4:0];
			core_ctrl_pkg::ALU_SRA:    alu_result = $signed(src1) >>> src2[4:0];
			core_ctrl_pkg::ALU_SLT:    alu_result = {{(`XLEN-1){1'b0}}, signed_lt};
			core_ctrl_pkg::ALU_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, unsigned_lt};
			core_ctrl_pkg::ALU_PASS_B: alu_result = src2;
			default:                   alu_result = '0;
		endcase
	end

	// Comparator shares the operands the ALU sees
	always_comb begin
		case (brnch_cnd)
			core_ctrl_pkg::BR_EQ:  brnch_taken = equal;
			core_ctrl_pkg::BR_NE:  brnch_taken = !equal;
			core_ctrl_pkg::BR_LT:  brnch_taken = signed_lt;
			core_ctrl_pkg::BR_GE:  brnch_taken = !signed_lt;
			core_ctrl_pkg::BR_LTU: brnch_taken = unsigned_lt;
			core_ctrl_pkg::BR_GEU: brnch_taken = !unsigned_lt;
			default:               brnch_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/core_ctrl_pkg.sv
/*
 * Control-field encodings carried by a decoded instruction.
 * The bubble value of a memory access is MEM_NOT_REQ.
 */
`default_nettype none

package core_ctrl_pkg;

	// ALU operations. Shifts use the low five bits of operand B
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLL    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_SLT    = 4'd8,
		ALU_SLTU   = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	// Branch conditions compare the two ALU inputs
	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LT   = 3'd3,
		BR_GE   = 3'd4,
		BR_LTU  = 3'd5,
		BR_GEU  = 3'd6
	} brnch_cnd_t;

	typedef enum logic {
		MEM_REQ_NONE = 1'b0,
		MEM_REQ      = 1'b1
	} mem_req_t;

	typedef enum logic [1:0] {
		MEM_SIZE_B = 2'd0,
		MEM_SIZE_H = 2'd1,
		MEM_SIZE_W = 2'd2
	} mem_size_t;

	// Seven bit access descriptor, top three bits reserved
	typedef struct packed {
		logic [2:0] spare;
		mem_req_t   req;
		logic       write;
		mem_size_t  size;
	} mem_acc_t;

	localparam mem_acc_t MEM_NOT_REQ = '{
		spare: 3'b000,
		req:   MEM_REQ_NONE,
		write: 1'b0,
		size:  MEM_SIZE_W
	};

	// Load extension, bypass for every instruction that is not a load
	typedef enum logic [2:0] {
		WB_EXT_BP = 3'd0,
		WB_EXT_SB = 3'd1,
		WB_EXT_UB = 3'd2,
		WB_EXT_SH = 3'd3,
		WB_EXT_UH = 3'd4,
		WB_EXT_W  = 3'd5
	} wb_ext_t;

	typedef enum logic [1:0] {
		SRC_REG = 2'd0,
		SRC_MEM = 2'd1,
		SRC_WB  = 2'd2
	} src_sel_t;

endpackage

`default_nettype wire

//--- verilog/core_data_pkg.sv
/*
 * Instruction and pipeline register layouts.
 * Register numbers are 5 bits; register 0 is never written back.
 */
`default_nettype none

`include "core_defines.svh"

package core_data_pkg;

	// Decoded instruction as it enters execute
	typedef struct packed {
		logic [`XLEN-1:0]         src1;
		logic [`XLEN-1:0]         src2;
		logic [`XLEN-1:0]         pc;
		logic [`XLEN-1:0]         pc_4;
		logic [`XLEN-1:0]         imm;
		logic [4:0]               rs1;
		logic [4:0]               rs2;
		logic [4:0]               rd;
		core_ctrl_pkg::alu_op_t    alu_op;
		core_ctrl_pkg::brnch_cnd_t brnch_cnd;
		core_ctrl_pkg::mem_acc_t   mem_acc;
		core_ctrl_pkg::wb_ext_t    wb_ext;
		logic                     a_is_pc;
		logic                     b_is_imm;
		logic                     addr_base_pc;
		logic                     link;
		logic                     we;
	} exe_in_t;

	// Execute to memory register
	typedef struct packed {
		logic [`XLEN-1:0]       alu_result;
		logic [`XLEN-1:0]       addr;
		logic [`XLEN-1:0]       w_data;
		logic [`XLEN-1:0]       pc_4;
		logic [4:0]             rd;
		logic                   we;
		logic                   link;
		core_ctrl_pkg::mem_acc_t mem_acc;
		core_ctrl_pkg::wb_ext_t  wb_ext;
	} exe_mem_t;

	// Writeback result
	typedef struct packed {
		logic             we;
		logic [4:0]       rd;
		logic [`XLEN-1:0] data;
	} mem_wb_t;

endpackage

`default_nettype wire

//--- verilog/core_exe_mem.sv
/*
 * Execute and memory stages of the core.
 * The source must not issue a consumer of a load in the next cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_exe_mem (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   exe_enb,
	input  logic                   exe_kill,
	input  core_data_pkg::exe_in_t exe_in,
	output logic                   brnch_taken,
	output core_data_pkg::mem_wb_t wb
);

	core_ctrl_pkg::src_sel_t sel1;
	core_ctrl_pkg::src_sel_t sel2;
	core_data_pkg::exe_mem_t exe_mem;
	logic [`XLEN-1:0]        fwd_mem;

	core_fwd i_core_fwd (
		.rs1    (exe_in.rs1),
		.rs2    (exe_in.rs2),
		.mem_rd (exe_mem.rd),
		.wb_rd  (wb.rd),
		.mem_we (exe_mem.we),
		.wb_we  (wb.we),
		.sel1   (sel1),
		.sel2   (sel2)
	);

	core_exe_s i_core_exe_s (
		.clk         (clk),
		.rst_n       (rst_n),
		.exe_enb     (exe_enb),
		.exe_kill    (exe_kill),
		.exe_in      (exe_in),
		.sel1        (sel1),
		.sel2        (sel2),
		.fwd_mem     (fwd_mem),
		.fwd_wb      (wb.data),
		.brnch_taken (brnch_taken),
		.exe_mem     (exe_mem)
	);

	core_mem_s i_core_mem_s (
		.clk     (clk),
		.rst_n   (rst_n),
		.exe_enb (exe_enb),
		.exe_mem (exe_mem),
		.fwd_mem (fwd_mem),
		.wb      (wb)
	);

endmodule

`default_nettype wire

//--- verilog/core_exe_s.sv
/*
 * Execute stage and the execute/memory register.
 * exe_kill loads a bubble whether or not exe_enb is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_exe_s (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    exe_enb,
	input  logic                    exe_kill,
	input  core_data_pkg::exe_in_t  exe_in,
	input  core_ctrl_pkg::src_sel_t sel1,
	input  core_ctrl_pkg::src_sel_t sel2,
	input  logic [`XLEN-1:0]        fwd_mem,
	input  logic [`XLEN-1:0]        fwd_wb,
	output logic                    brnch_taken,
	output core_data_pkg::exe_mem_t exe_mem
);

	localparam core_data_pkg::exe_mem_t EXE_MEM_BUBBLE = '{
		alu_result: '0,
		addr:       '0,
		w_data:     '0,
		pc_4:       '0,
		rd:         5'd0,
		we:         1'b0,
		link:       1'b0,
		mem_acc:    core_ctrl_pkg::MEM_NOT_REQ,
		wb_ext:     core_ctrl_pkg::WB_EXT_BP
	};

	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic [`XLEN-1:0] alu_a;
	logic [`XLEN-1:0] alu_b;
	logic [`XLEN-1:0] alu_result;
	logic [`XLEN-1:0] addr_base;
	logic [`XLEN-1:0] addr;

	function automatic logic [`XLEN-1:0] resolve(
		input core_ctrl_pkg::src_sel_t sel,
		input logic [`XLEN-1:0]        reg_val,
		input logic [`XLEN-1:0]        mem_val,
		input logic [`XLEN-1:0]        wb_val
	);
		logic [`XLEN-1:0] val;
		case (sel)
			core_ctrl_pkg::SRC_MEM: val = mem_val;
			core_ctrl_pkg::SRC_WB:  val = wb_val;
			default:                val = reg_val;
		endcase
		return val;
	endfunction

	// ************************************************************************
	// Operands and address
	// ************************************************************************

	assign op1 = resolve(sel1, exe_in.src1, fwd_mem, fwd_wb);
	assign op2 = resolve(sel2, exe_in.src2, fwd_mem, fwd_wb);

	assign alu_a = exe_in.a_is_pc ? exe_in.pc : op1;
	assign alu_b = exe_in.b_is_imm ? exe_in.imm : op2;

	// Loads and stores use the register base, jumps may use the pc
	assign addr_base = exe_in.addr_base_pc ? exe_in.pc : op1;
	assign addr      = exe_in.imm + addr_base;

	core_alu i_core_alu (
		.src1        (alu_a),
		.src2        (alu_b),
		.alu_op      (exe_in.alu_op),
		.brnch_cnd   (exe_in.brnch_cnd),
		.alu_result  (alu_result),
		.brnch_taken (brnch_taken)
	);

	// ************************************************************************
	// Execute/memory register
	// ************************************************************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			exe_mem <= EXE_MEM_BUBBLE;
		end else if (exe_kill) begin
			exe_mem <= EXE_MEM_BUBBLE;
		end else if (exe_enb) begin
			exe_mem.alu_result <= alu_result;
			exe_mem.addr       <= addr;
			exe_mem.w_data     <= op2;
			exe_mem.pc_4       <= exe_in.pc_4;
			exe_mem.rd         <= exe_in.rd;
			exe_mem.we         <= exe_in.we;
			exe_mem.link       <= exe_in.link;
			exe_mem.mem_acc    <= exe_in.mem_acc;
			exe_mem.wb_ext     <= exe_in.wb_ext;
		end
	end

endmodule

`default_nettype wire

//--- verilog/core_fwd.sv
/*
 * Bypass selection for both execute operands.
 * A load result is not available from the memory stage in time.
 */
`timescale 1ns/1ps
`default_nettype none

module core_fwd (
	input  logic [4:0]              rs1,
	input  logic [4:0]              rs2,
	input  logic [4:0]              mem_rd,
	input  logic [4:0]              wb_rd,
	input  logic                    mem_we,
	input  logic                    wb_we,
	output core_ctrl_pkg::src_sel_t sel1,
	output core_ctrl_pkg::src_sel_t sel2
);

	// The younger result in memory wins over the one in writeback
	function automatic core_ctrl_pkg::src_sel_t pick_src(
		input logic [4:0] rs,
		input logic [4:0] m_rd,
		input logic       m_we,
		input logic [4:0] w_rd,
		input logic       w_we
	);
		core_ctrl_pkg::src_sel_t sel;
		if (rs == 5'd0)
			sel = core_ctrl_pkg::SRC_REG;
		else if (m_we && (m_rd == rs))
			sel = core_ctrl_pkg::SRC_MEM;
		else if (w_we && (w_rd == rs))
			sel = core_ctrl_pkg::SRC_WB;
		else
			sel = core_ctrl_pkg::SRC_REG;
		return sel;
	endfunction

	assign sel1 = pick_src(rs1, mem_rd, mem_we, wb_rd, wb_we);
	assign sel2 = pick_src(rs2, mem_rd, mem_we, wb_rd, wb_we);

endmodule

`default_nettype wire

//--- verilog/core_mem_s.sv
/*
 * Memory stage with a private word-addressed data RAM.
 * Misaligned halves and words are not split; the low address bits select lanes only.
 */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_mem_s (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    exe_enb,
	input  core_data_pkg::exe_mem_t exe_mem,
	output logic [`XLEN-1:0]        fwd_mem,
	output core_data_pkg::mem_wb_t  wb
);

	logic [`XLEN-1:0]   dmem [`DMEM_WORDS];
	logic [`DMEM_AW-1:0] word_idx;
	logic               is_load;
	logic               is_store;
	logic [3:0]         byte_en;
	logic [`XLEN-1:0]   wr_word;
	logic [`XLEN-1:0]   rd_word;
	logic [`XLEN-1:0]   rd_lane;
	logic [`XLEN-1:0]   load_data;

	assign word_idx = exe_mem.addr[`DMEM_AW+1:2];
	assign is_load  = (exe_mem.mem_acc.req == core_ctrl_pkg::MEM_REQ) && !exe_mem.mem_acc.write;
	assign is_store = (exe_mem.mem_acc.req == core_ctrl_pkg::MEM_REQ) && exe_mem.mem_acc.write;

	// Non-load result, also what the execute stage bypasses
	assign fwd_mem = exe_mem.link ? exe_mem.pc_4 : exe_mem.alu_result;

	// ************************************************************************
	// Store path
	// ************************************************************************

	// Narrow data is replicated so every enabled lane sees it
	always_comb begin
		case (exe_mem.mem_acc.size)
			core_ctrl_pkg::MEM_SIZE_B: begin
				byte_en = 4'b0001 << exe_mem.addr[1:0];
				wr_word = {4{exe_mem.w_data[7:0]}};
			end
			core_ctrl_pkg::MEM_SIZE_H: begin
				byte_en = exe_mem.addr[1] ? 4'b1100 : 4'b0011;
				wr_word = {2{exe_mem.w_data[15:0]}};
			end
			default: begin
				byte_en = 4'b1111;
				wr_word = exe_mem.w_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (exe_enb && is_store) begin
			for (int i = 0; i < 4; i++) begin
				if (byte_en[i])
					dmem[word_idx][8*i +: 8] <= wr_word[8*i +: 8];
			end
		end
	end

	// ************************************************************************
	// Load path and writeback register
	// ************************************************************************

	assign rd_word = dmem[word_idx];
	assign rd_lane = rd_word >> {exe_mem.addr[1:0], 3'b000};

	always_comb begin
		case (exe_mem.wb_ext)
			core_ctrl_pkg::WB_EXT_SB: load_data = {{24{rd_lane[7]}}, rd_lane[7:0]};
			core_ctrl_pkg::WB_EXT_UB: load_data = {24'd0, rd_lane[7:0]};
			core_ctrl_pkg::WB_EXT_SH: load_data = {{16{rd_lane[15]}}, rd_lane[15:0]};
			core_ctrl_pkg::WB_EXT_UH: load_data = {16'd0, rd_lane[15:0]};
			core_ctrl_pkg::WB_EXT_W:  load_data = rd_word;
			default:                  load_data = fwd_mem;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb <= '0;
		end else if (exe_enb) begin
			wb.we   <= exe_mem.we;
			wb.rd   <= exe_mem.rd;
			wb.data <= is_load ? load_data : fwd_mem;
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
verilog/core_ctrl_pkg.sv
verilog/core_data_pkg.sv
verilog/core_alu.sv
verilog/core_fwd.sv
verilog/core_exe_s.sv
verilog/core_mem_s.sv
verilog/core_exe_mem.sv
test/tb_core_exe_mem.sv
